// ==== build.f ====
verilog/mem_edge_pkg.sv
verilog/heap_free_list.sv
verilog/write_packet_tracker.sv
verilog/write_data_heap.sv
verilog/afu_write_edge.sv
verilog/mem_write_edge_top.sv
testbench/tb_mem_write_edge.sv

// ==== testbench/tb_mem_write_edge.sv ====
// ======================================================================
// Self-checking testbench for the memory write edge top level:
// clock and reset, packet stimulus, request and heap content model,
// almost-full model and the checks on all DUT outputs
// ======================================================================

`default_nettype none

module tb_mem_write_edge
    import mem_edge_pkg::*;
();

    timeunit 1ns;
    timeprecision 1ps;

    localparam int N_HEAP_ENTRIES = 32;
    localparam int IDX_BITS = $clog2(N_HEAP_ENTRIES);
    localparam int CYCLE_LIMIT = 2000;

    logic                clk = 1'b0;
    logic                reset;
    logic                wr_valid;
    logic                wr_sop;
    t_cl_len             wr_cl_len;
    t_line_addr          wr_addr;
    t_cl_data            wr_data;
    logic                afu_reset;
    logic                wr_almost_full;
    logic                req_valid;
    t_line_addr          req_addr;
    t_cl_len             req_cl_len;
    logic [IDX_BITS-1:0] req_heap_idx;
    logic                mem_almost_full;
    logic                rd_en;
    logic [IDX_BITS-1:0] rd_heap_idx;
    t_beat_num           rd_beat;
    t_cl_data            rd_data;
    logic                free;
    logic [IDX_BITS-1:0] free_idx;

    // Marks the last beat of the packet being driven
    logic                beat_last;

    logic [31:0] rng_state = 32'hc0a991b4;
    int          cycle_count = 0;
    int          error_count = 0;

    // Free slots as the DUT should see them, and the request due this cycle
    int          free_model = N_HEAP_ENTRIES;
    logic        req_due = 1'b0;

    // Expected requests in packet order, with every beat's data
    t_line_addr  exp_addr_q[$];
    t_cl_len     exp_len_q[$];
    t_cl_data    exp_data_q[$];

    // Requests seen so far that still own their index
    int          rcvd_idx_q[$];
    t_cl_len     rcvd_len_q[$];

    t_cl_data    model_mem [N_HEAP_ENTRIES][MAX_BEATS];
    bit          outstanding [N_HEAP_ENTRIES];
    bit          was_freed [N_HEAP_ENTRIES];

    mem_write_edge_top
    #(
        .N_HEAP_ENTRIES(N_HEAP_ENTRIES)
    )
    mem_write_edge_top_inst
    (
        .clk,
        .reset,
        .wr_valid,
        .wr_sop,
        .wr_cl_len,
        .wr_addr,
        .wr_data,
        .afu_reset,
        .wr_almost_full,
        .req_valid,
        .req_addr,
        .req_cl_len,
        .req_heap_idx,
        .mem_almost_full,
        .rd_en,
        .rd_heap_idx,
        .rd_beat,
        .rd_data,
        .free,
        .free_idx
    );

    always #10 clk = ~clk;

    // ==================================================================
    // Failure reporting and random numbers
    // ==================================================================

    task automatic end_with_failure();
        $display("Verification failed");
        $fatal(1);
    endtask

    task automatic report_mismatch(input string msg);
        error_count++;
        $display("CHECK FAILED at time %0t: %s", $time, msg);
        end_with_failure();
    endtask

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    function automatic logic [31:0] next_random();
        rng_state = xorshift32(rng_state);
        return rng_state;
    endfunction

    // ==================================================================
    // Reference models and checks
    // ==================================================================

    // Runaway guard counted in clock cycles
    always @(posedge clk)
    begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= CYCLE_LIMIT)
        begin
            $display("Timeout: the run did not finish within %0d cycles", CYCLE_LIMIT);
            end_with_failure();
        end
    end

    // An index is taken on each last beat and given back on each free strobe
    always @(posedge clk)
    begin
        if (reset)
        begin
            free_model <= N_HEAP_ENTRIES;
            req_due <= 1'b0;
        end
        else
        begin
            free_model <= free_model - int'(wr_valid && beat_last) + int'(free);
            req_due <= wr_valid && beat_last;
        end
    end

    // Both accelerator-facing flags are forced high by reset
    reset_flags_high: assert property (@(posedge clk) reset |=> (wr_almost_full && afu_reset))
        else report_mismatch("almost-full or accelerator reset low during reset");

    // Accelerator reset trails the edge reset by exactly one cycle
    afu_reset_held: assert property (@(posedge clk) $fell(reset) |-> afu_reset)
        else report_mismatch("accelerator reset released together with reset");

    afu_reset_released: assert property (@(posedge clk)
        $fell(reset) |=> (!afu_reset && !wr_almost_full))
        else report_mismatch("accelerator reset or almost-full high after reset");

    // With free slots above the reserve only downstream pressure counts
    almost_full_follows: assert property (@(posedge clk) disable iff (reset)
        (free_model > HEAP_MIN_FREE_SLOTS) |=> (wr_almost_full == $past(mem_almost_full)))
        else report_mismatch("almost-full does not follow downstream almost-full");

    task automatic check_request();
        t_line_addr exp_a;
        t_cl_len    exp_l;
        int         idx;
        int         b;
        exp_a = exp_addr_q.pop_front();
        exp_l = exp_len_q.pop_front();
        idx = int'(req_heap_idx);
        assert (req_addr == exp_a)
            else report_mismatch($sformatf("req_addr %h, expected %h", req_addr, exp_a));
        assert (req_cl_len == exp_l)
            else report_mismatch($sformatf("req_cl_len %0d, expected %0d", req_cl_len, exp_l));
        assert (!outstanding[idx])
            else report_mismatch($sformatf("heap index %0d handed out twice", idx));
        outstanding[idx] = 1'b1;
        // Beats land at the packet's index in beat order
        for (b = 0; b <= int'(exp_l); b++)
        begin
            model_mem[idx][b] = exp_data_q.pop_front();
        end
        rcvd_idx_q.push_back(idx);
        rcvd_len_q.push_back(exp_l);
    endtask

    // Outputs are sampled mid-cycle where registers are settled
    always @(negedge clk)
    begin
        if (cycle_count > 0)
        begin
            assert (req_valid === req_due)
                else report_mismatch($sformatf("req_valid %b, expected %b", req_valid, req_due));
            if (req_valid === 1'b1)
            begin
                check_request();
            end
        end
    end

    // ==================================================================
    // Stimulus tasks, all entered and left 2 ns after a rising edge
    // ==================================================================

    task automatic next_cycle();
        @(posedge clk);
        #2;
    endtask

    // Non-start beats get random address and length to prove they are ignored
    task automatic send_packet(input t_line_addr addr, input t_cl_len len);
        t_cl_data data;
        int       b;
        for (b = 0; b <= int'(len); b++)
        begin
            data = {next_random(), next_random()};
            exp_data_q.push_back(data);
            wr_valid = 1'b1;
            wr_sop = (b == 0);
            wr_data = data;
            wr_addr = (b == 0) ? addr : next_random();
            wr_cl_len = (b == 0) ? len : t_cl_len'(next_random());
            beat_last = (b == int'(len));
            if (beat_last)
            begin
                exp_addr_q.push_back(addr);
                exp_len_q.push_back(len);
            end
            next_cycle();
        end
        wr_valid = 1'b0;
        wr_sop = 1'b0;
        beat_last = 1'b0;
    endtask

    // The global cycle limit bounds this wait
    task automatic wait_for_requests();
        while (exp_addr_q.size() != 0)
        begin
            next_cycle();
        end
    endtask

    task automatic read_line(input int idx, input int beat);
        rd_en = 1'b1;
        rd_heap_idx = IDX_BITS'(idx);
        rd_beat = t_beat_num'(beat);
        next_cycle();
        rd_en = 1'b0;
        @(negedge clk);
        assert (rd_data == model_mem[idx][beat])
            else report_mismatch($sformatf("heap %0d beat %0d read %h, expected %h",
                                           idx, beat, rd_data, model_mem[idx][beat]));
        next_cycle();
    endtask

    task automatic free_index(input int idx);
        free = 1'b1;
        free_idx = IDX_BITS'(idx);
        outstanding[idx] = 1'b0;
        was_freed[idx] = 1'b1;
        next_cycle();
        free = 1'b0;
    endtask

    // Read every beat of the oldest received packet, then return its index
    task automatic drain_oldest();
        int      idx;
        t_cl_len len;
        int      b;
        idx = rcvd_idx_q.pop_front();
        len = rcvd_len_q.pop_front();
        for (b = 0; b <= int'(len); b++)
        begin
            read_line(idx, b);
        end
        free_index(idx);
    endtask

    // ==================================================================
    // Test sequence
    // ==================================================================

    initial
    begin
        int idx;

        reset = 1'b1;
        wr_valid = 1'b0;
        wr_sop = 1'b0;
        wr_cl_len = '0;
        wr_addr = '0;
        wr_data = '0;
        beat_last = 1'b0;
        mem_almost_full = 1'b0;
        rd_en = 1'b0;
        rd_heap_idx = '0;
        rd_beat = '0;
        free = 1'b0;
        free_idx = '0;

        repeat (5) @(posedge clk);
        #2;
        reset = 1'b0;
        next_cycle();

        // Single-line write
        send_packet(next_random(), 2'd0);
        wait_for_requests();
        drain_oldest();

        // Two- and four-line packets sent back to back
        for (int i = 0; i < 8; i++)
        begin
            send_packet(next_random(), (i % 2 == 0) ? 2'd1 : 2'd3);
        end
        wait_for_requests();
        while (rcvd_idx_q.size() != 0)
        begin
            drain_oldest();
        end

        // Fill the heap down to its reserve with no frees
        for (int i = 0; i < 19; i++)
        begin
            send_packet(next_random(), 2'd0);
        end
        wait_for_requests();
        assert (wr_almost_full)
            else report_mismatch("almost-full low with only the reserve left");
        foreach (rcvd_idx_q[i])
        begin
            read_line(rcvd_idx_q[i], 0);
        end

        // Returning ten indices lifts almost-full and makes them reusable
        foreach (was_freed[i])
        begin
            was_freed[i] = 1'b0;
        end
        repeat (10)
        begin
            void'(rcvd_len_q.pop_front());
            free_index(rcvd_idx_q.pop_front());
        end
        next_cycle();
        assert (!wr_almost_full)
            else report_mismatch("almost-full still high after frees");
        send_packet(next_random(), 2'd0);
        wait_for_requests();
        idx = rcvd_idx_q[$];
        assert (was_freed[idx])
            else report_mismatch($sformatf("index %0d was not a freed one", idx));
        while (rcvd_idx_q.size() != 0)
        begin
            drain_oldest();
        end

        // Downstream almost-full toggled while the heap has room
        repeat (24)
        begin
            mem_almost_full = next_random() & 32'h1;
            next_cycle();
        end
        mem_almost_full = 1'b0;
        next_cycle();
        next_cycle();

        if (error_count == 0)
        begin
            $display("Verification passed");
            $finish;
        end
        else
        begin
            end_with_failure();
        end
    end

endmodule

`default_nettype wire

// ==== verilog/mem_write_edge_top.sv ====
// ======================================================================
// Memory write edge top level: connects the accelerator edge,
// packet tracker, heap free list and write data heap
// ======================================================================

`default_nettype none

module mem_write_edge_top
    import mem_edge_pkg::*;
#(
    parameter int N_HEAP_ENTRIES = 32
)
(
    input  wire logic                              clk,
    input  wire logic                              reset,

    // Accelerator write channel
    input  wire logic                              wr_valid,
    input  wire logic                              wr_sop,
    input  wire t_cl_len                           wr_cl_len,
    input  wire t_line_addr                        wr_addr,
    input  wire t_cl_data                          wr_data,
    output logic                                   afu_reset,
    output logic                                   wr_almost_full,

    // Control requests toward downstream
    output logic                                   req_valid,
    output t_line_addr                             req_addr,
    output t_cl_len                                req_cl_len,
    output logic [$clog2(N_HEAP_ENTRIES)-1:0]      req_heap_idx,
    input  wire logic                              mem_almost_full,

    // Downstream heap read and index return
    input  wire logic                              rd_en,
    input  wire logic [$clog2(N_HEAP_ENTRIES)-1:0] rd_heap_idx,
    input  wire t_beat_num                         rd_beat,
    output t_cl_data                               rd_data,
    input  wire logic                              free,
    input  wire logic [$clog2(N_HEAP_ENTRIES)-1:0] free_idx
);

    localparam int IDX_BITS = $clog2(N_HEAP_ENTRIES);

    t_beat_num           beat_num;
    logic                eop;
    t_line_addr          sop_addr;
    t_cl_len             sop_cl_len;
    logic [IDX_BITS-1:0] alloc_idx;
    logic                not_full;
    logic                alloc;

    afu_write_edge
    #(
        .N_HEAP_ENTRIES(N_HEAP_ENTRIES)
    )
    afu_write_edge_inst
    (
        .clk,
        .reset,
        .wr_valid,
        .wr_sop,
        .wr_cl_len,
        .wr_addr,
        .beat_num,
        .eop,
        .sop_addr,
        .sop_cl_len,
        .alloc_idx,
        .not_full,
        .alloc,
        .mem_almost_full,
        .req_valid,
        .req_addr,
        .req_cl_len,
        .req_heap_idx,
        .wr_almost_full,
        .afu_reset
    );

    write_packet_tracker write_packet_tracker_inst
    (
        .clk,
        .reset,
        .wr_valid,
        .wr_sop,
        .wr_cl_len,
        .wr_addr,
        .beat_num,
        .eop,
        .sop_addr,
        .sop_cl_len
    );

    // Reserve leaves room for one whole packet past the threshold
    heap_free_list
    #(
        .N_HEAP_ENTRIES(N_HEAP_ENTRIES),
        .MIN_FREE_SLOTS(HEAP_MIN_FREE_SLOTS)
    )
    heap_free_list_inst
    (
        .clk,
        .reset,
        .alloc,
        .alloc_idx,
        .not_full,
        .free,
        .free_idx
    );

    // Every accelerator beat lands at the packet's index and its beat number
    write_data_heap
    #(
        .N_HEAP_ENTRIES(N_HEAP_ENTRIES)
    )
    write_data_heap_inst
    (
        .clk,
        .wen(wr_valid),
        .widx(alloc_idx),
        .wbeat(beat_num),
        .wdata(wr_data),
        .rd_en,
        .rd_heap_idx,
        .rd_beat,
        .rd_data
    );

endmodule

`default_nettype wire

// ==== verilog/afu_write_edge.sv ====
// ======================================================================
// Accelerator-side write edge: canonical header, one control request
// per packet, heap allocation strobe, merged almost-full and the
// delayed accelerator reset
// ======================================================================

`default_nettype none

module afu_write_edge
    import mem_edge_pkg::*;
#(
    parameter int N_HEAP_ENTRIES = 32
)
(
    input  wire logic                              clk,
    input  wire logic                              reset,

    // Accelerator write beat
    input  wire logic                              wr_valid,
    input  wire logic                              wr_sop,
    input  wire t_cl_len                           wr_cl_len,
    input  wire t_line_addr                        wr_addr,

    // From the packet tracker
    input  wire t_beat_num                         beat_num,
    input  wire logic                              eop,
    input  wire t_line_addr                        sop_addr,
    input  wire t_cl_len                           sop_cl_len,

    // Free list handshake
    input  wire logic [$clog2(N_HEAP_ENTRIES)-1:0] alloc_idx,
    input  wire logic                              not_full,
    output logic                                   alloc,

    input  wire logic                              mem_almost_full,

    // Control request toward downstream
    output logic                                   req_valid,
    output t_line_addr                             req_addr,
    output t_cl_len                                req_cl_len,
    output logic [$clog2(N_HEAP_ENTRIES)-1:0]      req_heap_idx,

    output logic                                   wr_almost_full,
    output logic                                   afu_reset
);

    t_line_addr hdr_addr;
    t_cl_len    hdr_cl_len;

    // ==================================================================
    // Canonical header
    // ==================================================================

    // Address and length of non-start beats are don't-care, so the
    // saved start-beat copy is used in their place
    assign hdr_addr = wr_sop ? wr_addr : sop_addr;
    assign hdr_cl_len = wr_sop ? wr_cl_len : sop_cl_len;

    // The packet is complete when the tracker flags eop on the beat whose
    // number matches the canonical length.  The heap index is consumed then
    assign alloc = wr_valid && eop && (beat_num == hdr_cl_len);

    // ==================================================================
    // Control request
    // ==================================================================

    // Only the last beat produces a request, so all of the packet's data
    // is already in the heap when downstream sees it
    always_ff @(posedge clk)
    begin
        req_valid <= alloc;

        if (reset)
        begin
            req_valid <= 1'b0;
        end
    end

    always_ff @(posedge clk)
    begin
        if (alloc)
        begin
            req_addr <= hdr_addr;
            req_cl_len <= hdr_cl_len;
            req_heap_idx <= alloc_idx;
        end
    end

    // ==================================================================
    // Flow control and reset toward the accelerator
    // ==================================================================

    // Downstream pressure and a low free list both stop the accelerator.
    // Held high through reset so nothing is sent before the edge is ready
    always_ff @(posedge clk)
    begin
        wr_almost_full <= mem_almost_full || !not_full;

        if (reset)
        begin
            wr_almost_full <= 1'b1;
        end
    end

    // Accelerator leaves reset one cycle after the edge
    always_ff @(posedge clk)
    begin
        afu_reset <= reset;
    end

endmodule

`default_nettype wire

// ==== verilog/write_data_heap.sv ====
// ======================================================================
// Write data heap: one cache line per heap index and beat number,
// written by the accelerator side and read by downstream
// ======================================================================

`default_nettype none

module write_data_heap
    import mem_edge_pkg::*;
#(
    parameter int N_HEAP_ENTRIES = 32
)
(
    input  wire logic                              clk,

    // Write port, one line per accelerator beat
    input  wire logic                              wen,
    input  wire logic [$clog2(N_HEAP_ENTRIES)-1:0] widx,
    input  wire t_beat_num                         wbeat,
    input  wire t_cl_data                          wdata,

    // Read port owned by downstream
    input  wire logic                              rd_en,
    input  wire logic [$clog2(N_HEAP_ENTRIES)-1:0] rd_heap_idx,
    input  wire t_beat_num                         rd_beat,
    output t_cl_data                               rd_data
);

    localparam int DEPTH = N_HEAP_ENTRIES * MAX_BEATS;

    // Lines are stored as {index, beat}, so each index owns MAX_BEATS slots
    t_cl_data mem [DEPTH];

    always_ff @(posedge clk)
    begin
        if (wen)
        begin
            mem[{widx, wbeat}] <= wdata;
        end

        // Read data appears one cycle after rd_en
        if (rd_en)
        begin
            rd_data <= mem[{rd_heap_idx, rd_beat}];
        end
    end

endmodule

`default_nettype wire

// ==== verilog/write_packet_tracker.sv ====
// ======================================================================
// Multi-beat write tracker: beat counter, end-of-packet detection
// and the saved start-of-packet address and length
// ======================================================================

`default_nettype none

module write_packet_tracker
    import mem_edge_pkg::*;
(
    input  wire logic       clk,
    input  wire logic       reset,

    // Current beat from the accelerator
    input  wire logic       wr_valid,
    input  wire logic       wr_sop,
    input  wire t_cl_len    wr_cl_len,
    input  wire t_line_addr wr_addr,

    output t_beat_num       beat_num,
    output logic            eop,
    output t_line_addr      sop_addr,
    output t_cl_len         sop_cl_len
);

    // Position of the next expected non-start beat
    t_beat_num beat_cnt;
    t_cl_len   eff_cl_len;

    // A start beat is always beat zero, whatever the counter says
    assign beat_num = wr_sop ? '0 : beat_cnt;

    // Non-start beats may carry junk length, so use the saved code
    assign eff_cl_len = wr_sop ? wr_cl_len : sop_cl_len;

    assign eop = wr_valid && (beat_num == eff_cl_len);

    // ==================================================================
    // Beat counter
    // ==================================================================

    always_ff @(posedge clk)
    begin
        if (wr_valid)
        begin
            if (eop)
            begin
                beat_cnt <= '0;
            end
            else
            begin
                beat_cnt <= beat_num + 1'b1;
            end
        end

        if (reset)
        begin
            beat_cnt <= '0;
        end
    end

    // Header fields from the start beat are kept for the rest of the packet
    always_ff @(posedge clk)
    begin
        if (wr_valid && wr_sop)
        begin
            sop_addr <= wr_addr;
            sop_cl_len <= wr_cl_len;
        end
    end

endmodule

`default_nettype wire

// ==== verilog/heap_free_list.sv ====
// ======================================================================
// Write heap index allocator: one busy flag per index, a registered
// lowest-free index and a free count that drives not_full
// ======================================================================

`default_nettype none

module heap_free_list
#(
    parameter int N_HEAP_ENTRIES = 32,
    parameter int MIN_FREE_SLOTS = 13
)
(
    input  wire logic                              clk,
    input  wire logic                              reset,

    // Claim the index currently on alloc_idx
    input  wire logic                              alloc,
    output logic [$clog2(N_HEAP_ENTRIES)-1:0]      alloc_idx,
    output logic                                   not_full,

    // Return an index once downstream is done with it
    input  wire logic                              free,
    input  wire logic [$clog2(N_HEAP_ENTRIES)-1:0] free_idx
);

    localparam int IDX_BITS = $clog2(N_HEAP_ENTRIES);
    localparam int CNT_BITS = $clog2(N_HEAP_ENTRIES + 1);

    logic [N_HEAP_ENTRIES-1:0] busy;
    logic [N_HEAP_ENTRIES-1:0] busy_next;
    logic [IDX_BITS-1:0]       next_idx;
    logic [CNT_BITS-1:0]       free_cnt;

    // Apply this cycle's alloc and free to the flags, then pick the
    // lowest clear flag so a freed index is visible one cycle later
    always_comb
    begin
        busy_next = busy;
        if (alloc)
        begin
            busy_next[alloc_idx] = 1'b1;
        end
        if (free)
        begin
            busy_next[free_idx] = 1'b0;
        end

        // Scan downward so the lowest free index wins
        next_idx = '0;
        for (int i = N_HEAP_ENTRIES - 1; i >= 0; i--)
        begin
            if (!busy_next[i])
            begin
                next_idx = IDX_BITS'(i);
            end
        end
    end

    always_ff @(posedge clk)
    begin
        busy <= busy_next;
        alloc_idx <= next_idx;

        // An alloc and a free in the same cycle cancel out
        if (alloc && !free)
        begin
            free_cnt <= free_cnt - 1'b1;
        end
        else if (free && !alloc)
        begin
            free_cnt <= free_cnt + 1'b1;
        end

        if (reset)
        begin
            busy <= '0;
            alloc_idx <= '0;
            free_cnt <= CNT_BITS'(N_HEAP_ENTRIES);
        end
    end

    // Drop not_full while only the reserve is left
    assign not_full = (free_cnt > CNT_BITS'(MIN_FREE_SLOTS));

endmodule

`default_nettype wire

// ==== verilog/mem_edge_pkg.sv ====
// ======================================================================
// Shared definitions for the memory write edge:
// cache line and address widths, length codes, beat numbers
// and the flow-control thresholds used by the free list
// ======================================================================

`default_nettype none

package mem_edge_pkg;

    // Width of one cache line of data in this scaled-down design
    localparam int CL_DATA_BITS = 64;

    // Width of a cache-line address
    localparam int LINE_ADDR_BITS = 32;

    // Longest packet the accelerator may send, in beats
    localparam int MAX_BEATS = 4;

    typedef logic [CL_DATA_BITS-1:0] t_cl_data;
    typedef logic [LINE_ADDR_BITS-1:0] t_line_addr;

    // Length code: 0 is one line, 1 is two lines, 3 is four lines.
    // The code value is also the number of the last beat of the packet
    typedef logic [1:0] t_cl_len;

    // Beat position inside a packet
    typedef logic [1:0] t_beat_num;

    // Requests the accelerator may still issue after seeing almost-full
    localparam int ALMOST_FULL_THRESHOLD = 8;

    // Keep room for the threshold plus one whole packet, so almost-full
    // can rise in the middle of a packet and the rest still fits
    localparam int HEAP_MIN_FREE_SLOTS = ALMOST_FULL_THRESHOLD + MAX_BEATS + 1;

endpackage

`default_nettype wire
